//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN   = 64;
    localparam int ILEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    // imm field 1, every other field zero
    localparam logic [ILEN-1:0] INST_EBREAK = {12'h001, 13'h0000, OPC_SYSTEM};

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_none
    } inst_fmt_e;

    typedef enum logic [5:0] {
        op_add, op_sub, op_and, op_or, op_slt, op_sltu,    // rv64i R-type
        op_addw, op_subw, op_sllw, op_srlw, op_sraw,
        op_addi, op_andi, op_xori, op_slli, op_srli, op_srai, op_sltiu,
        op_addiw, op_slliw, op_srliw, op_sraiw,
        op_ld, op_lw, op_lh, op_lhu, op_lbu,
        op_sd, op_sw, op_sh, op_sb,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_jal, op_jalr, op_lui, op_auipc,
        op_ebreak,
        op_illegal
    } rv_op_e;

endpackage

//--- design/decode_ctrl_pkg.sv
package decode_ctrl_pkg;

    localparam int QUEUE_DEPTH = 4;    // producer starts with this many credits
    localparam int OUT_CREDITS = 2;    // consumer buffer slots
    localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CW    = $clog2(QUEUE_DEPTH + 1);
    localparam int OUT_CW      = $clog2(OUT_CREDITS + 1);

    typedef enum logic [3:0] {
        alu_none, alu_add, alu_add_align, alu_sll, alu_srl, alu_sra,
        alu_addw, alu_subw, alu_sllw, alu_srlw, alu_sraw,
        alu_sub, alu_and, alu_or, alu_xor
    } alu_op_e;

    typedef enum logic [1:0] {
        src_rs1_rs2,
        src_rs1_imm,
        src_pc_imm
    } alu_src_e;

    typedef enum logic [2:0] {
        wb_none, wb_alu, wb_snpc, wb_imm, wb_mem,
        wb_cmp    // 1 when the compare holds, else 0
    } wb_src_e;

    typedef enum logic [1:0] {
        pc_snpc,
        pc_alu,
        pc_alu_if_cmp
    } pc_src_e;

    typedef enum logic [2:0] {
        cmp_none, cmp_eq, cmp_ne, cmp_lt, cmp_ge, cmp_ltu, cmp_geu
    } cmp_op_e;

    typedef enum logic {
        cmp_src_rs2,
        cmp_src_imm
    } cmp_src_e;

    typedef enum logic [3:0] {
        mem_none, mem_ld, mem_lw, mem_lh, mem_lhu, mem_lbu,
        mem_sd, mem_sw, mem_sh, mem_sb
    } mem_op_e;

    typedef struct packed {
        alu_op_e  alu_op;
        alu_src_e alu_src;
        wb_src_e  wb_src;
        pc_src_e  pc_src;
        cmp_op_e  cmp_op;
        cmp_src_e cmp_src;
        mem_op_e  mem_op;
    } decode_ctrl_t;

    typedef struct packed {
        logic                        valid;
        logic [rv_isa_pkg::ILEN-1:0] inst;
        rv_isa_pkg::rv_op_e          op;
        rv_isa_pkg::inst_fmt_e       fmt;
    } match_slot_t;

    typedef struct packed {
        logic                          valid;
        rv_isa_pkg::rv_op_e            op;
        logic [rv_isa_pkg::XLEN-1:0]   imm;
        logic [rv_isa_pkg::REG_AW-1:0] rd;
        logic [rv_isa_pkg::REG_AW-1:0] rs1;
        logic [rv_isa_pkg::REG_AW-1:0] rs2;
    } imm_slot_t;

    typedef struct packed {
        decode_ctrl_t                  ctrl;
        logic [rv_isa_pkg::XLEN-1:0]   imm;
        logic [rv_isa_pkg::REG_AW-1:0] rd;
        logic [rv_isa_pkg::REG_AW-1:0] rs1;
        logic [rv_isa_pkg::REG_AW-1:0] rs2;
        logic                          illegal;
        logic                          ebreak;
    } decoded_inst_t;

endpackage

//--- design/decode_match_stage.sv
`timescale 1ns/100ps

module decode_match_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [rv_isa_pkg::ILEN-1:0]  in_inst,
    output decode_ctrl_pkg::match_slot_t match_out
);

    import rv_isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rv_op_e     op;
    inst_fmt_e  fmt;

    assign opcode = in_inst[6:0];
    assign funct3 = in_inst[14:12];
    assign funct7 = in_inst[31:25];

    always_comb begin
        casez ({funct7, funct3, opcode})
            {7'b0000000, 3'b000, OPC_OP}:        op = op_add;
            {7'b0100000, 3'b000, OPC_OP}:        op = op_sub;
            {7'b0000000, 3'b111, OPC_OP}:        op = op_and;
            {7'b0000000, 3'b110, OPC_OP}:        op = op_or;
            {7'b0000000, 3'b010, OPC_OP}:        op = op_slt;
            {7'b0000000, 3'b011, OPC_OP}:        op = op_sltu;
            {7'b0000000, 3'b000, OPC_OP_32}:     op = op_addw;
            {7'b0100000, 3'b000, OPC_OP_32}:     op = op_subw;
            {7'b0000000, 3'b001, OPC_OP_32}:     op = op_sllw;
            {7'b0000000, 3'b101, OPC_OP_32}:     op = op_srlw;
            {7'b0100000, 3'b101, OPC_OP_32}:     op = op_sraw;
            {7'b???????, 3'b000, OPC_OP_IMM}:    op = op_addi;
            {7'b???????, 3'b111, OPC_OP_IMM}:    op = op_andi;
            {7'b???????, 3'b100, OPC_OP_IMM}:    op = op_xori;
            {7'b???????, 3'b011, OPC_OP_IMM}:    op = op_sltiu;
            {7'b000000?, 3'b001, OPC_OP_IMM}:    op = op_slli;    // shamt[5] in funct7[0]
            {7'b000000?, 3'b101, OPC_OP_IMM}:    op = op_srli;
            {7'b010000?, 3'b101, OPC_OP_IMM}:    op = op_srai;
            {7'b???????, 3'b000, OPC_OP_IMM_32}: op = op_addiw;
            {7'b0000000, 3'b001, OPC_OP_IMM_32}: op = op_slliw;
            {7'b0000000, 3'b101, OPC_OP_IMM_32}: op = op_srliw;
            {7'b0100000, 3'b101, OPC_OP_IMM_32}: op = op_sraiw;
            {7'b???????, 3'b011, OPC_LOAD}:      op = op_ld;
            {7'b???????, 3'b010, OPC_LOAD}:      op = op_lw;
            {7'b???????, 3'b001, OPC_LOAD}:      op = op_lh;
            {7'b???????, 3'b101, OPC_LOAD}:      op = op_lhu;
            {7'b???????, 3'b100, OPC_LOAD}:      op = op_lbu;
            {7'b???????, 3'b011, OPC_STORE}:     op = op_sd;
            {7'b???????, 3'b010, OPC_STORE}:     op = op_sw;
            {7'b???????, 3'b001, OPC_STORE}:     op = op_sh;
            {7'b???????, 3'b000, OPC_STORE}:     op = op_sb;
            {7'b???????, 3'b000, OPC_BRANCH}:    op = op_beq;
            {7'b???????, 3'b001, OPC_BRANCH}:    op = op_bne;
            {7'b???????, 3'b100, OPC_BRANCH}:    op = op_blt;
            {7'b???????, 3'b101, OPC_BRANCH}:    op = op_bge;
            {7'b???????, 3'b110, OPC_BRANCH}:    op = op_bltu;
            {7'b???????, 3'b111, OPC_BRANCH}:    op = op_bgeu;
            {7'b???????, 3'b000, OPC_JALR}:      op = op_jalr;
            {7'b???????, 3'b???, OPC_JAL}:       op = op_jal;
            {7'b???????, 3'b???, OPC_LUI}:       op = op_lui;
            {7'b???????, 3'b???, OPC_AUIPC}:     op = op_auipc;
            default:                             op = op_illegal;
        endcase
        if (in_inst == INST_EBREAK) begin
            op = op_ebreak;
        end

        case (opcode)
            OPC_OP, OPC_OP_32:                             fmt = fmt_r;
            OPC_OP_IMM, OPC_OP_IMM_32, OPC_LOAD, OPC_JALR: fmt = fmt_i;
            OPC_STORE:                                     fmt = fmt_s;
            OPC_BRANCH:                                    fmt = fmt_b;
            OPC_LUI, OPC_AUIPC:                            fmt = fmt_u;
            OPC_JAL:                                       fmt = fmt_j;
            default:                                       fmt = fmt_none;
        endcase
        if (op == op_illegal) begin
            fmt = fmt_none;    // bad funct bits under a good opcode
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_out.valid <= 1'b0;
        end else begin
            match_out.valid <= in_valid;
        end
        if (in_valid) begin
            match_out.inst <= in_inst;
            match_out.op   <= op;
            match_out.fmt  <= fmt;
        end
    end

endmodule

//--- design/decode_imm_stage.sv
`timescale 1ns/100ps

module decode_imm_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  decode_ctrl_pkg::match_slot_t match_in,
    output decode_ctrl_pkg::imm_slot_t   imm_out
);

    import rv_isa_pkg::*;

    logic [ILEN-1:0] inst;
    logic [XLEN-1:0] imm;

    assign inst = match_in.inst;

    always_comb begin
        case (match_in.fmt)
            fmt_i:   imm = {{(XLEN-12){inst[31]}}, inst[31:20]};
            fmt_s:   imm = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            fmt_b:   imm = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u:   imm = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            fmt_j:   imm = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;    // R-type and unmatched
        endcase
    end

    // register fields sit at fixed positions in every format
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            imm_out.valid <= 1'b0;
        end else begin
            imm_out.valid <= match_in.valid;
        end
        if (match_in.valid) begin
            imm_out.op  <= match_in.op;
            imm_out.imm <= imm;
            imm_out.rd  <= inst[11:7];
            imm_out.rs1 <= inst[19:15];
            imm_out.rs2 <= inst[24:20];
        end
    end

endmodule

//--- design/decode_ctrl_stage.sv
`timescale 1ns/100ps

module decode_ctrl_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  decode_ctrl_pkg::imm_slot_t     imm_in,
    output logic                           dec_valid,
    output decode_ctrl_pkg::decoded_inst_t dec_out
);

    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    decode_ctrl_t ctrl;

    always_comb begin
        ctrl = '0;    // all-none bundle, kept for illegal and ebreak

        case (imm_in.op)
            op_add, op_addi, op_jal, op_auipc,
            op_ld, op_lw, op_lh, op_lhu, op_lbu, op_sd, op_sw, op_sh, op_sb,
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: ctrl.alu_op = alu_add;
            op_jalr:           ctrl.alu_op = alu_add_align;
            op_sub:            ctrl.alu_op = alu_sub;
            op_and, op_andi:   ctrl.alu_op = alu_and;
            op_or:             ctrl.alu_op = alu_or;
            op_xori:           ctrl.alu_op = alu_xor;
            op_slli:           ctrl.alu_op = alu_sll;
            op_srli:           ctrl.alu_op = alu_srl;
            op_srai:           ctrl.alu_op = alu_sra;
            op_addw, op_addiw: ctrl.alu_op = alu_addw;
            op_subw:           ctrl.alu_op = alu_subw;
            op_sllw, op_slliw: ctrl.alu_op = alu_sllw;
            op_srlw, op_srliw: ctrl.alu_op = alu_srlw;
            op_sraw, op_sraiw: ctrl.alu_op = alu_sraw;
            default:           ctrl.alu_op = alu_none;
        endcase

        case (imm_in.op)
            op_addi, op_andi, op_xori, op_slli, op_srli, op_srai,
            op_addiw, op_slliw, op_srliw, op_sraiw, op_jalr,
            op_ld, op_lw, op_lh, op_lhu, op_lbu,
            op_sd, op_sw, op_sh, op_sb: ctrl.alu_src = src_rs1_imm;
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
            op_jal, op_auipc:           ctrl.alu_src = src_pc_imm;
            default:                    ctrl.alu_src = src_rs1_rs2;
        endcase

        case (imm_in.op)
            op_slt, op_sltu, op_sltiu:              ctrl.wb_src = wb_cmp;
            op_ld, op_lw, op_lh, op_lhu, op_lbu:    ctrl.wb_src = wb_mem;
            op_jal, op_jalr:                        ctrl.wb_src = wb_snpc;   // link
            op_lui:                                 ctrl.wb_src = wb_imm;
            op_sd, op_sw, op_sh, op_sb, op_ebreak, op_illegal,
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: ctrl.wb_src = wb_none;
            default:                                ctrl.wb_src = wb_alu;
        endcase

        case (imm_in.op)
            op_jal, op_jalr: ctrl.pc_src = pc_alu;
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: ctrl.pc_src = pc_alu_if_cmp;
            default:         ctrl.pc_src = pc_snpc;
        endcase

        // datapath resolves the outcome, decoder only names the test
        case (imm_in.op)
            op_beq:                     ctrl.cmp_op = cmp_eq;
            op_bne:                     ctrl.cmp_op = cmp_ne;
            op_slt, op_blt:             ctrl.cmp_op = cmp_lt;
            op_bge:                     ctrl.cmp_op = cmp_ge;
            op_sltu, op_sltiu, op_bltu: ctrl.cmp_op = cmp_ltu;
            op_bgeu:                    ctrl.cmp_op = cmp_geu;
            default:                    ctrl.cmp_op = cmp_none;
        endcase
        if (imm_in.op == op_sltiu) begin
            ctrl.cmp_src = cmp_src_imm;
        end

        case (imm_in.op)
            op_ld:   ctrl.mem_op = mem_ld;
            op_lw:   ctrl.mem_op = mem_lw;
            op_lh:   ctrl.mem_op = mem_lh;
            op_lhu:  ctrl.mem_op = mem_lhu;
            op_lbu:  ctrl.mem_op = mem_lbu;
            op_sd:   ctrl.mem_op = mem_sd;
            op_sw:   ctrl.mem_op = mem_sw;
            op_sh:   ctrl.mem_op = mem_sh;
            op_sb:   ctrl.mem_op = mem_sb;
            default: ctrl.mem_op = mem_none;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= imm_in.valid;
        end
        if (imm_in.valid) begin
            dec_out.ctrl    <= ctrl;
            dec_out.imm     <= imm_in.imm;
            dec_out.rd      <= imm_in.rd;
            dec_out.rs1     <= imm_in.rs1;
            dec_out.rs2     <= imm_in.rs2;
            dec_out.illegal <= (imm_in.op == op_illegal);
            dec_out.ebreak  <= (imm_in.op == op_ebreak);
        end
    end

endmodule

//--- design/decode_credit_queue.sv
`timescale 1ns/100ps

module decode_credit_queue (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           dec_valid,
    input  decode_ctrl_pkg::decoded_inst_t dec_in,
    output logic                           in_credit,
    output logic                           out_valid,
    output decode_ctrl_pkg::decoded_inst_t out_inst,
    input  logic                           out_credit
);

    import decode_ctrl_pkg::*;

    decoded_inst_t       slots [QUEUE_DEPTH];
    logic [QUEUE_AW-1:0] wr_ptr;
    logic [QUEUE_AW-1:0] rd_ptr;
    logic [QUEUE_CW-1:0] count;
    logic [OUT_CW-1:0]   out_cnt;

    // head goes out only while the consumer has room
    assign out_valid = (count != '0) && (out_cnt != '0);
    assign out_inst  = slots[rd_ptr];

    // input credits bound the items in flight, so a write never finds the queue full
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            slots[wr_ptr] <= dec_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_cnt   <= OUT_CW'(OUT_CREDITS);
            in_credit <= 1'b0;
        end else begin
            if (dec_valid) begin
                wr_ptr <= wr_ptr + QUEUE_AW'(1);
            end
            if (out_valid) begin
                rd_ptr <= rd_ptr + QUEUE_AW'(1);
            end
            count     <= count + QUEUE_CW'(dec_valid) - QUEUE_CW'(out_valid);
            out_cnt   <= out_cnt + OUT_CW'(out_credit) - OUT_CW'(out_valid);
            in_credit <= out_valid;    // freed slot goes back to the producer
        end
    end

endmodule

//--- design/rv64_decoder.sv
`timescale 1ns/100ps

module rv64_decoder (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  logic [rv_isa_pkg::ILEN-1:0]    in_inst,
    output logic                           in_credit,
    output logic                           out_valid,
    output decode_ctrl_pkg::decoded_inst_t out_inst,
    input  logic                           out_credit
);

    import decode_ctrl_pkg::*;

    match_slot_t   match_slot;
    imm_slot_t     imm_slot;
    logic          dec_valid;
    decoded_inst_t dec_inst;

    decode_match_stage u_match (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_inst   (in_inst),
        .match_out (match_slot)
    );

    decode_imm_stage u_imm (
        .clk      (clk),
        .rst_n    (rst_n),
        .match_in (match_slot),
        .imm_out  (imm_slot)
    );

    decode_ctrl_stage u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .imm_in    (imm_slot),
        .dec_valid (dec_valid),
        .dec_out   (dec_inst)
    );

    decode_credit_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_valid  (dec_valid),
        .dec_in     (dec_inst),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_inst   (out_inst),
        .out_credit (out_credit)
    );

endmodule

//--- test/tb_rv64_decoder.sv
`timescale 1ns/100ps

module tb_rv64_decoder;

    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    localparam int NUM_CASES  = 28;
    localparam int FIELDS     = 14;    // words per line in the case file
    localparam int HOLD_START = 30;    // consumer keeps its credits in this window
    localparam int HOLD_LEN   = 60;

    logic            clk;
    logic            rst_n      = 1'b0;
    logic            in_valid   = 1'b0;
    logic [ILEN-1:0] in_inst    = '0;
    logic            out_credit = 1'b0;
    logic            in_credit;
    logic            out_valid;
    decoded_inst_t   out_inst;

    logic [63:0] case_mem [0:NUM_CASES*FIELDS-1];
    logic [31:0] rnd_state       = 32'd87;
    logic        withhold        = 1'b0;
    int          credits         = QUEUE_DEPTH;
    int          sent_count      = 0;
    int          recv_count      = 0;
    int          returned        = 0;
    int          pending         = 0;
    int          cycle_count     = 0;
    int          mismatch_errors = 0;
    int          flow_errors     = 0;
    int          load_errors     = 0;
    int          timeouts        = 0;

    rv64_decoder u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_inst   (out_inst),
        .out_credit (out_credit)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic decoded_inst_t expected_decode(input int idx);
        decoded_inst_t e;
        int            b;
        b = idx * FIELDS;
        e.ctrl.alu_op  = alu_op_e'(case_mem[b+1][3:0]);
        e.ctrl.alu_src = alu_src_e'(case_mem[b+2][1:0]);
        e.ctrl.wb_src  = wb_src_e'(case_mem[b+3][2:0]);
        e.ctrl.pc_src  = pc_src_e'(case_mem[b+4][1:0]);
        e.ctrl.cmp_op  = cmp_op_e'(case_mem[b+5][2:0]);
        e.ctrl.cmp_src = cmp_src_e'(case_mem[b+6][0]);
        e.ctrl.mem_op  = mem_op_e'(case_mem[b+7][3:0]);
        e.imm          = case_mem[b+8];
        e.rd           = case_mem[b+9][REG_AW-1:0];
        e.rs1          = case_mem[b+10][REG_AW-1:0];
        e.rs2          = case_mem[b+11][REG_AW-1:0];
        e.illegal      = case_mem[b+12][0];
        e.ebreak       = case_mem[b+13][0];
        return e;
    endfunction

    task automatic check_output(input int idx);
        decoded_inst_t exp;
        exp = expected_decode(idx);
        if (out_inst !== exp) begin
            mismatch_errors++;
            $display("mismatch case %0d (inst %h): expected %h actual %h",
                     idx, case_mem[idx*FIELDS][ILEN-1:0], exp, out_inst);
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatch, %0d flow, %0d load, %0d timeout",
                 mismatch_errors, flow_errors, load_errors, timeouts);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // producer, consumer and credit checks share one random stream
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count++;
            rnd_state = next_random(rnd_state);
            if (sent_count == 0 && (out_valid || in_credit)) begin
                flow_errors++;
                $display("out_valid or in_credit high before the first instruction was sent");
            end
            if (in_credit) begin
                credits++;
                if (credits > QUEUE_DEPTH) begin
                    flow_errors++;
                    $display("input credits rose to %0d, above the queue depth", credits);
                end
            end
            if (out_valid) begin
                if (recv_count >= NUM_CASES) begin
                    flow_errors++;
                    $display("extra output after all %0d cases were received", NUM_CASES);
                end else begin
                    check_output(recv_count);
                end
                recv_count++;
                pending++;
                if (recv_count > sent_count) begin
                    flow_errors++;
                    $display("%0d outputs but only %0d words sent", recv_count, sent_count);
                end
                if (recv_count > OUT_CREDITS + returned) begin
                    flow_errors++;
                    $display("%0d outputs with only %0d output credits returned",
                             recv_count, returned);
                end
            end
            if (credits > 0 && sent_count < NUM_CASES && rnd_state[1:0] != 2'b00) begin
                in_valid <= 1'b1;
                in_inst  <= case_mem[sent_count*FIELDS][ILEN-1:0];
                credits--;
                sent_count++;
            end else begin
                in_valid <= 1'b0;
            end
            withhold = (cycle_count >= HOLD_START) && (cycle_count < HOLD_START + HOLD_LEN);
            if (pending > 0 && !withhold && rnd_state[9:8] != 2'b00) begin
                out_credit <= 1'b1;
                pending--;
                returned++;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    initial begin
        $readmemh("test/decode_cases.txt", case_mem);
        if ($isunknown(case_mem[0])) begin
            load_errors++;
            $display("could not read the case file test/decode_cases.txt");
        end else begin
            repeat (5) @(posedge clk);
            rst_n <= 1'b1;
            wait (recv_count == NUM_CASES);
            repeat (20) @(posedge clk);    // room for a duplicate to show up
        end
        report_counts();
        if (mismatch_errors + flow_errors + load_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (NUM_CASES * 40) @(posedge clk);
        timeouts++;
        $display("timeout after %0d cycles, %0d of %0d outputs received",
                 NUM_CASES * 40, recv_count, NUM_CASES);
        report_counts();
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- test/decode_cases.txt
// inst     alu src wb pc cmp csrc mem imm              rd rs1 rs2 ill ebrk
// one instruction per line, control fields as enum codes, all hex
002081b3 1 0 1 0 0 0 0 0000000000000000 03 01 02 0 0
407302b3 b 0 1 0 0 0 0 0000000000000000 05 06 07 0 0
00c5f533 c 0 1 0 0 0 0 0000000000000000 0a 0b 0c 0 0
0062a233 0 0 5 0 3 0 0 0000000000000000 04 05 06 0 0
009433b3 0 0 5 0 5 0 0 0000000000000000 07 08 09 0 0
003100bb 6 0 1 0 0 0 0 0000000000000000 01 02 03 0 0
40a4d43b a 0 1 0 0 0 0 0000000000000000 08 09 0a 0 0
fff10093 1 1 1 0 0 0 0 ffffffffffffffff 01 02 1f 0 0
7f027193 c 1 1 0 0 0 0 00000000000007f0 03 04 10 0 0
80034293 e 1 1 0 0 0 0 fffffffffffff800 05 06 00 0 0
02141393 3 1 1 0 0 0 0 0000000000000021 07 08 01 0 0
40555493 5 1 1 0 0 0 0 0000000000000405 09 0a 05 0 0
00163593 0 0 5 0 5 1 0 0000000000000001 0b 0c 01 0 0
7ff0809b 6 1 1 0 0 0 0 00000000000007ff 01 01 1f 0 0
ff813503 1 1 4 0 0 0 1 fffffffffffffff8 0a 02 18 0 0
00635283 1 1 4 0 0 0 4 0000000000000006 05 06 06 0 0
fe513823 1 1 0 0 0 0 6 fffffffffffffff0 10 02 05 0 0
026380a3 1 1 0 0 0 0 9 0000000000000021 01 07 06 0 0
fe208ee3 1 2 0 2 1 0 0 fffffffffffffffc 1d 01 02 0 0
0062e0e3 1 2 0 2 5 0 0 0000000000000800 01 05 06 0 0
800000b7 0 0 3 0 0 0 0 ffffffff80000000 01 00 00 0 0
12345117 1 2 1 0 0 0 0 0000000012345000 02 08 03 0 0
ff9ff0ef 1 2 2 1 0 0 0 fffffffffffffff8 01 1f 19 0 0
001002ef 1 2 2 1 0 0 0 0000000000000800 05 00 01 0 0
00c280e7 2 1 2 1 0 0 0 000000000000000c 01 05 0c 0 0
022081b3 0 0 0 0 0 0 0 0000000000000000 03 01 02 1 0
00000000 0 0 0 0 0 0 0 0000000000000000 00 00 00 1 0
00100073 0 0 0 0 0 0 0 0000000000000000 00 00 01 0 1

//--- rv64_decoder.f
design/rv_isa_pkg.sv
design/decode_ctrl_pkg.sv
design/decode_match_stage.sv
design/decode_imm_stage.sv
design/decode_ctrl_stage.sv
design/decode_credit_queue.sv
design/rv64_decoder.sv
test/tb_rv64_decoder.sv

//--- Makefile
SIM := obj_dir/Vtb_rv64_decoder

$(SIM): rv64_decoder.f $(wildcard design/*.sv test/*.sv)
	verilator --binary -Wno-fatal --top-module tb_rv64_decoder -f rv64_decoder.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
